// ==== logic/oled_drv.sv ====
`default_nettype none

module oled_drv #(
    parameter int unsigned write_interval = oled_pkg::WRITE_INTERVAL_DEF
) (
    input wire              clk,
    input wire              rst_n,
    input wire              i2c_done,   // writer finished a transfer
    output oled_pkg::byte_t word_addr,  // control byte
    output oled_pkg::byte_t wdata,      // payload byte
    output logic            exec        // start one write
);

    logic init_done;

    oled_word_if init_word_bus ();
    oled_word_if frame_word_bus ();

    oled_init_seq u_init_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_word (init_word_bus.source)
    );

    oled_frame_seq u_frame_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (init_done),
        .frame_word (frame_word_bus.source)
    );

    oled_write_pacer #(
        .write_interval (write_interval)
    ) u_write_pacer (
        .clk        (clk),
        .rst_n      (rst_n),
        .i2c_done   (i2c_done),
        .init_word  (init_word_bus.sink),
        .frame_word (frame_word_bus.sink),
        .init_done  (init_done),
        .word_addr  (word_addr),
        .wdata      (wdata),
        .exec       (exec)
    );

endmodule

`default_nettype wire

// ==== logic/oled_font_rom.sv ====
`default_nettype none

module oled_font_rom (
    input wire [3:0]        char_idx,  // position in "Hello World"
    input wire [2:0]        col,       // column within the glyph
    input wire              lower,     // lower half, page 1
    output oled_pkg::byte_t column_bits
);

    // 16 bytes per glyph, first 8 are the upper half
    logic [0:15][7:0] glyph;

    // ----------------------------------------
    // 8x16 glyphs, one per text position
    // ----------------------------------------
    always_comb begin
        case (char_idx)
            4'd0: begin  // H
                glyph = 128'h08F8_0800_0008_F808_203F_2101_0121_3F20;
            end
            4'd1: begin  // e
                glyph = 128'h0000_8080_8080_0000_001F_2424_2424_1700;
            end
            4'd2, 4'd3, 4'd9: begin  // l
                glyph = 128'h0010_10F8_0000_0000_0020_203F_2020_0000;
            end
            4'd4, 4'd7: begin  // o
                glyph = 128'h0000_8080_8080_0000_001F_2020_2020_1F00;
            end
            4'd6: begin  // W
                glyph = 128'h08F8_00F8_00F8_0800_0003_3E01_3E03_0000;
            end
            4'd8: begin  // r
                glyph = 128'h8080_8000_8080_8000_2020_3F21_2000_0100;
            end
            4'd10: begin  // d
                glyph = 128'h0000_8080_8090_F000_001F_2020_2010_3F20;
            end
            default: begin
                glyph = '0;  // space and beyond the text
            end
        endcase
    end

    assign column_bits = glyph[{lower, col}];

endmodule

`default_nettype wire

// ==== logic/oled_frame_seq.sv ====
`default_nettype none

module oled_frame_seq (
    input wire          clk,
    input wire          rst_n,
    input wire          run,   // init done, frames may start
    oled_word_if.source frame_word
);

    oled_pkg::frame_state_t state;
    oled_pkg::page_t        page;
    oled_pkg::slot_t        slot;
    oled_pkg::col_t         col;
    oled_pkg::byte_t        glyph_bits;
    logic                   in_text;

    // column only meaningful in FR_COLS
    assign col = oled_pkg::col_t'(slot - oled_pkg::PAGE_HDR_SLOTS);

    assign in_text = (page < oled_pkg::page_t'(oled_pkg::TEXT_PAGES))
                  && (col < oled_pkg::col_t'(oled_pkg::TEXT_LEN * oled_pkg::GLYPH_W));

    oled_font_rom u_font_rom (
        .char_idx    (col[6:3]),
        .col         (col[2:0]),
        .lower       (page[0]),
        .column_bits (glyph_bits)
    );

    // ----------------------------------------
    // page / slot walk
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= oled_pkg::FR_HDR;
            page  <= '0;
            slot  <= '0;
        end else if (!run) begin  // parked at page 0 header
            state <= oled_pkg::FR_HDR;
            page  <= '0;
            slot  <= '0;
        end else if (frame_word.step) begin
            case (state)
                oled_pkg::FR_HDR: begin
                    if (slot == oled_pkg::PAGE_HDR_SLOTS - 8'd1) begin
                        state <= oled_pkg::FR_COLS;
                    end
                    slot <= slot + 8'd1;
                end
                oled_pkg::FR_COLS: begin
                    if (slot == oled_pkg::PAGE_HDR_SLOTS + oled_pkg::PAGE_COLS - 8'd1) begin
                        state <= oled_pkg::FR_HDR;
                        slot  <= '0;
                        if (page == oled_pkg::page_t'(oled_pkg::PAGE_NUM - 1)) begin
                            page <= '0;  // next frame
                        end else begin
                            page <= page + 3'd1;
                        end
                    end else begin
                        slot <= slot + 8'd1;
                    end
                end
                default: state <= oled_pkg::FR_HDR;
            endcase
        end
    end

    // word for the current slot
    always_comb begin
        if (state == oled_pkg::FR_COLS) begin
            frame_word.ctrl    = oled_pkg::CTRL_DATA;
            frame_word.payload = in_text ? glyph_bits : 8'h00;
        end else begin
            frame_word.ctrl = oled_pkg::CTRL_CMD;
            case (slot)
                8'd0:    frame_word.payload = {5'b10110, page};  // page address
                8'd1:    frame_word.payload = 8'h00;             // low column 0
                default: frame_word.payload = 8'h10;             // high column 0
            endcase
        end
    end

    assign frame_word.exhausted = 1'b0;  // frames never end

    a_slot_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        slot < oled_pkg::PAGE_HDR_SLOTS + oled_pkg::PAGE_COLS
    ) else $error("frame slot out of range: %0d", slot);

endmodule

`default_nettype wire

// ==== logic/oled_init_seq.sv ====
`default_nettype none

module oled_init_seq (
    input wire          clk,
    input wire          rst_n,
    oled_word_if.source init_word
);

    oled_pkg::init_idx_t idx;

    // index parks at INIT_CMD_NUM once the table is done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (init_word.step && !init_word.exhausted) begin
            idx <= idx + 5'd1;
        end
    end

    assign init_word.exhausted = (idx == oled_pkg::INIT_CMD_NUM);
    assign init_word.ctrl      = oled_pkg::CTRL_CMD;

    // ----------------------------------------
    // power-up command table
    // ----------------------------------------
    always_comb begin
        case (idx)
            5'd0:    init_word.payload = 8'hAE;  // display off
            5'd1:    init_word.payload = 8'hAE;
            5'd2:    init_word.payload = 8'h00;  // low column start
            5'd3:    init_word.payload = 8'h10;  // high column start
            5'd4:    init_word.payload = 8'h40;  // start line 0
            5'd5:    init_word.payload = 8'h81;  // contrast
            5'd6:    init_word.payload = 8'hCF;
            5'd7:    init_word.payload = 8'hA1;  // segment remap
            5'd8:    init_word.payload = 8'hC8;  // com scan reversed
            5'd9:    init_word.payload = 8'hA6;  // normal, not inverted
            5'd10:   init_word.payload = 8'hA8;  // multiplex ratio
            5'd11:   init_word.payload = 8'h3F;  // 1/64 duty
            5'd12:   init_word.payload = 8'hD3;  // display offset
            5'd13:   init_word.payload = 8'h00;
            5'd14:   init_word.payload = 8'hD5;  // clock divide / osc
            5'd15:   init_word.payload = 8'h80;
            5'd16:   init_word.payload = 8'hD9;  // pre-charge period
            5'd17:   init_word.payload = 8'hF1;
            5'd18:   init_word.payload = 8'hDA;  // com pin config
            5'd19:   init_word.payload = 8'h12;
            5'd20:   init_word.payload = 8'hDB;  // vcomh level
            5'd21:   init_word.payload = 8'h40;
            5'd22:   init_word.payload = 8'h20;  // addressing mode
            5'd23:   init_word.payload = 8'h02;  // page mode
            5'd24:   init_word.payload = 8'h8D;  // charge pump
            5'd25:   init_word.payload = 8'h14;  // pump on
            5'd26:   init_word.payload = 8'hA4;  // follow RAM content
            5'd27:   init_word.payload = 8'hA6;
            5'd28:   init_word.payload = 8'hAF;  // display on
            default: init_word.payload = 8'hE3;  // nop past the table
        endcase
    end

    // pacer must stop stepping once the table has run out
    a_no_step_when_exhausted : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(init_word.step && init_word.exhausted)
    ) else $error("init step while exhausted");

endmodule

`default_nettype wire

// ==== logic/oled_pkg.sv ====
`default_nettype none

package oled_pkg;

    // ----------------------------------------
    // widths with a meaning
    // ----------------------------------------
    typedef logic [7:0] byte_t;      // control and payload bytes
    typedef logic [4:0] init_idx_t;  // init table index, 0..29
    typedef logic [6:0] col_t;       // column within a page
    typedef logic [2:0] page_t;      // page number
    typedef logic [7:0] slot_t;      // position within a page, 0..130

    // ----------------------------------------
    // SSD1306 control bytes
    // ----------------------------------------
    localparam byte_t CTRL_CMD  = 8'h00;
    localparam byte_t CTRL_DATA = 8'h40;

    // sequence sizes
    localparam init_idx_t INIT_CMD_NUM   = 5'd29;
    localparam slot_t     PAGE_HDR_SLOTS = 8'd3;    // page, low col, high col
    localparam slot_t     PAGE_COLS      = 8'd128;
    localparam int unsigned PAGE_NUM     = 8;

    // text layout
    localparam int unsigned TEXT_LEN   = 11;  // "Hello World"
    localparam int unsigned GLYPH_W    = 8;
    localparam int unsigned TEXT_PAGES = 2;   // upper and lower glyph halves

    // spacing of exec strobes in clk cycles
    localparam int unsigned WRITE_INTERVAL_DEF = 20000;

    typedef enum logic {
        FR_HDR,
        FR_COLS
    } frame_state_t;

endpackage

`default_nettype wire

// ==== logic/oled_word_if.sv ====
`default_nettype none

// one two-byte write word, sequencer to pacer
interface oled_word_if;

    oled_pkg::byte_t ctrl;     // control byte, command or data
    oled_pkg::byte_t payload;  // byte that follows the control byte
    logic            step;     // one-cycle advance to the next word
    logic            exhausted;

    modport source (
        output ctrl,
        output payload,
        output exhausted,
        input  step
    );

    modport sink (
        input  ctrl,
        input  payload,
        input  exhausted,
        output step
    );

endinterface

`default_nettype wire

// ==== logic/oled_write_pacer.sv ====
`default_nettype none

module oled_write_pacer #(
    parameter int unsigned write_interval = oled_pkg::WRITE_INTERVAL_DEF
) (
    input wire              clk,
    input wire              rst_n,
    input wire              i2c_done,
    oled_word_if.sink       init_word,
    oled_word_if.sink       frame_word,
    output logic            init_done,
    output oled_pkg::byte_t word_addr,
    output oled_pkg::byte_t wdata,
    output logic            exec
);

    logic [31:0] tick;
    logic        tick_end;
    logic        hold_off;  // gap between last init command and its done

    assign tick_end = (tick == write_interval - 32'd1);
    assign hold_off = init_word.exhausted && !init_done;

    // ----------------------------------------
    // interval timer and exec strobe
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= '0;
            exec <= 1'b0;
        end else begin
            tick <= tick_end ? 32'd0 : tick + 32'd1;  // runs through the gap too
            exec <= tick_end && !hold_off;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else if (init_word.exhausted && i2c_done) begin
            init_done <= 1'b1;
        end
    end

    // word source follows init_done
    assign word_addr       = init_done ? frame_word.ctrl : init_word.ctrl;
    assign wdata           = init_done ? frame_word.payload : init_word.payload;
    assign init_word.step  = exec && !init_done;
    assign frame_word.step = exec && init_done;

    a_exec_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        exec |=> !exec
    ) else $error("exec high two cycles in a row");

    a_init_done_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        init_done |=> init_done
    ) else $error("init_done fell");

endmodule

`default_nettype wire

// ==== project.f ====
logic/oled_pkg.sv
logic/oled_word_if.sv
logic/oled_init_seq.sv
logic/oled_font_rom.sv
logic/oled_frame_seq.sv
logic/oled_write_pacer.sv
logic/oled_drv.sv
testbench/tb_clock_gen.sv
testbench/tb_oled_drv.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the oled_drv testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_oled_drv
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$top" -f project.f -o "sim_$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./obj_dir/sim_$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    always #5 clk = ~clk;  // 10 ns period

endmodule

`default_nettype wire

// ==== testbench/tb_oled_drv.sv ====
`default_nettype none

module tb_oled_drv;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int INTERVAL   = 16;
    localparam int INIT_LEN   = 29;
    localparam int PAGE_SLOTS = 131;             // 3 header commands + 128 columns
    localparam int FRAME_LEN  = 8 * PAGE_SLOTS;  // 1048 writes
    localparam int RUN_EXECS  = INIT_LEN + 2 * FRAME_LEN;
    localparam int LIMIT      = (RUN_EXECS + 64) * INTERVAL;
    localparam logic [7:0] CTRL_CMD  = 8'h00;
    localparam logic [7:0] CTRL_DATA = 8'h40;
    localparam string TEXT = "Hello World";

    // power-up commands with the first one in the top byte
    localparam logic [INIT_LEN*8-1:0] INIT_CMDS = {
        64'hAEAE_0010_4081_CFA1, 64'hC8A6_A83F_D300_D580,
        64'hD9F1_DA12_DB40_2002, 40'h8D14_A4A6_AF
    };

    logic       clk;
    logic       rst_n;
    logic       i2c_done;
    logic [7:0] word_addr;
    logic [7:0] wdata;
    logic       exec;

    int cyc;       // rising edges since reset release
    int n_exec;
    int n_writes;  // writer's own count
    int prev_cyc;
    int done_cyc;  // cycle that samples the done of the last init write
    int mismatches;
    int failures;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    oled_drv #(
        .write_interval (INTERVAL)
    ) u_oled_drv (
        .clk       (clk),
        .rst_n     (rst_n),
        .i2c_done  (i2c_done),
        .word_addr (word_addr),
        .wdata     (wdata),
        .exec      (exec)
    );

    // ----------------------------------------
    // reference glyphs and checks
    // ----------------------------------------
    // upper half columns 0..7 then lower half columns 0..7
    function automatic logic [7:0] glyph_col(input byte ch, input int half, input int c);
        logic [127:0] g;
        case (ch)
            "H":     g = 128'h08F8_0800_0008_F808_203F_2101_0121_3F20;
            "e":     g = 128'h0000_8080_8080_0000_001F_2424_2424_1700;
            "l":     g = 128'h0010_10F8_0000_0000_0020_203F_2020_0000;
            "o":     g = 128'h0000_8080_8080_0000_001F_2020_2020_1F00;
            "W":     g = 128'h08F8_00F8_00F8_0800_0003_3E01_3E03_0000;
            "r":     g = 128'h8080_8000_8080_8000_2020_3F21_2000_0100;
            "d":     g = 128'h0000_8080_8090_F000_001F_2020_2010_3F20;
            default: g = '0;  // blank
        endcase
        return g[127 - 8 * (8 * half + c) -: 8];
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH %s at exec %0d: got 0x%h, expected 0x%h", name, n_exec, got, exp);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // sampled on the falling edge where outputs have settled
    always @(negedge clk) begin : monitor
        int         pos;
        int         page;
        int         slot;
        logic [7:0] exp_addr;
        logic [7:0] exp_data;
        if (!exec && n_exec == 0) begin  // reset word until the first exec
            compare_byte("word_addr", word_addr, CTRL_CMD);
            compare_byte("wdata", wdata, 8'hAE);
        end
        if (exec) begin
            n_exec++;
            if (n_exec == INIT_LEN + 1) begin
                assert (done_cyc >= 0) else begin
                    failures++;
                    $display("exec at cycle %0d before the last init write was done", cyc);
                end
                prev_cyc = (done_cyc / INTERVAL) * INTERVAL;  // next boundary after done
            end
            assert (cyc == prev_cyc + INTERVAL) else begin
                failures++;
                $display("exec %0d came at cycle %0d, expected cycle %0d",
                         n_exec, cyc, prev_cyc + INTERVAL);
            end
            prev_cyc = cyc;
            if (n_exec <= INIT_LEN) begin
                exp_addr = CTRL_CMD;
                exp_data = INIT_CMDS[(INIT_LEN - n_exec) * 8 +: 8];
            end else begin
                pos  = (n_exec - INIT_LEN - 1) % FRAME_LEN;  // wraps every frame
                page = pos / PAGE_SLOTS;
                slot = pos % PAGE_SLOTS;
                exp_addr = (slot < 3) ? CTRL_CMD : CTRL_DATA;
                case (slot)
                    0:       exp_data = 8'(32'hB0 + page);  // page address
                    1:       exp_data = 8'h00;
                    2:       exp_data = 8'h10;
                    default: begin
                        exp_data = 8'h00;
                        if (page < 2 && slot - 3 < 88) begin  // text area
                            exp_data = glyph_col(TEXT[(slot - 3) / 8], page, (slot - 3) % 8);
                        end
                    end
                endcase
            end
            compare_byte("word_addr", word_addr, exp_addr);
            compare_byte("wdata", wdata, exp_data);
        end
    end

    // ----------------------------------------
    // I2C writer model
    // ----------------------------------------
    initial begin : writer
        int unsigned delay;
        i2c_done = 1'b0;
        done_cyc = -1;
        void'($urandom(32'h7218f75f));
        repeat (LIMIT) begin
            @(negedge clk);
            if (exec) begin
                n_writes++;
                delay = ($urandom % 8) + 1;
                if (n_writes == INIT_LEN) begin
                    delay += 2 * INTERVAL;  // slow last init write opens a gap
                end
                repeat (delay) @(negedge clk);
                i2c_done = 1'b1;
                if (n_writes == INIT_LEN) begin
                    done_cyc = cyc + 1;
                end
                @(negedge clk);
                i2c_done = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int i;
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // init plus two frames
        for (i = 0; i < LIMIT && n_exec < RUN_EXECS; i++) begin
            @(posedge clk);
        end
        if (n_exec < RUN_EXECS) begin
            $display("timeout after %0d cycles, %0d of %0d execs seen", i, n_exec, RUN_EXECS);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0 && n_exec >= RUN_EXECS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
